/* source/gus_io_defs.svh */
/*
 * GUS16 I/O block constants
 * Clock and baud rate, the UART bit divider, the PWM counter width
 * and the offsets of the registers in the I/O page.
 */

`ifndef GUS_IO_DEFS_SVH
`define GUS_IO_DEFS_SVH

// ------------------------------------------------------------
// Clocking and serial rate
// ------------------------------------------------------------
`define GUS_FCLK          24000000                                       // System clock in Hz
`define GUS_BAUD          115200                                         // Serial bit rate
`define GUS_UART_DIVIDER  ((`GUS_FCLK + (`GUS_BAUD / 2)) / `GUS_BAUD)    // Clocks per bit, rounded
`define GUS_PWM_BITS      8                                              // PWM counter width

// ------------------------------------------------------------
// Register offsets within the I/O page
// ------------------------------------------------------------
`define GUS_REG_IRQEN     3'd0  // Interrupt enable
`define GUS_REG_PFLAGS    3'd1  // Peripheral flags, PWM duty on write
`define GUS_REG_UART      3'd2  // UART data
`define GUS_REG_TIMER     3'd3  // Timer, not fitted
`define GUS_REG_GPIO      3'd4  // General purpose in/out
`define GUS_REG_SDCLR     3'd6  // Screen dirty clear

`endif

/* source/gus_io_pkg.sv */
/*
 * GUS16 I/O block types
 * Bus word, UART byte, register offset and interrupt vector.
 */

package gus_io_pkg;

	// ------------------------------------------------------------
	// Bus side
	// ------------------------------------------------------------

	// 16-bit CPU data word
	typedef logic [15:0] word_t;

	// Offset of a register within the I/O page
	typedef logic [2:0] reg_addr_t;

	// Encoded interrupt source, lowest number wins
	typedef logic [1:0] irq_vec_t;

	// ------------------------------------------------------------
	// Peripheral side
	// ------------------------------------------------------------

	// UART payload, 8N1 frames
	typedef logic [7:0] byte_t;

endpackage

/* source/uart_tx.sv */
/*
 * UART transmitter, 8 data bits, no parity, one stop bit
 * A write loads a start zero and the data into a shift register.
 * Ones are shifted in behind it so the line rests high when done.
 */

`include "gus_io_defs.svh"

module uart_tx #(
	parameter int DIVIDER = `GUS_UART_DIVIDER	// Clocks per bit
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                tx_start,	// Accepted write of a byte
	input  gus_io_pkg::byte_t   tx_data,
	output logic                tx_ready,	// Idle, can take a byte
	output logic                txd
);

	localparam int DBITS = $clog2(DIVIDER);

	logic [DBITS-1:0] tx_div;	// Bit time divider
	logic             tx_wrap;	// End of a bit time
	logic [8:0]       tx_sh;	// Start + data, LSB on the line
	logic [3:0]       tx_bits;	// Bits left, 0 when idle

	assign tx_wrap = (tx_div == DBITS'(DIVIDER - 1));

	// ------------------------------------------------------------
	// Bit timing
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			tx_div <= '0;
		else if (tx_start || tx_wrap)
			tx_div <= '0;	// Realign on every new byte
		else
			tx_div <= tx_div + 1'b1;
	end

	// ------------------------------------------------------------
	// Shift register and bit counter
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_sh   <= 9'h1FF;	// Line idles high
			tx_bits <= 4'd0;
		end else if (tx_start) begin
			tx_sh   <= {tx_data, 1'b0};	// Data plus start bit
			tx_bits <= 4'd10;	// Start, 8 data, stop
		end else if (tx_wrap) begin
			tx_sh <= {1'b1, tx_sh[8:1]};	// A one becomes the stop bit
			if (tx_bits != 4'd0)
				tx_bits <= tx_bits - 1'b1;
		end
	end

	assign txd      = tx_sh[0];
	assign tx_ready = (tx_bits == 4'd0);

endmodule

/* source/uart_rx.sv */
/*
 * UART receiver, 8 data bits, one stop bit
 * The line is synchronized, the bit divider realigns on each edge
 * and samples near the middle of a bit. A frame is complete when the
 * start zero reaches the bottom of the shift register.
 */

`include "gus_io_defs.svh"

module uart_rx #(
	parameter int DIVIDER = `GUS_UART_DIVIDER	// Clocks per bit
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                rxd,
	input  logic                rx_ack,	// Accepted read, clears flags
	output gus_io_pkg::byte_t   rx_data,
	output logic                rx_valid,
	output logic                rx_overrun,
	output logic                rx_frame_err
);

	import gus_io_pkg::*;

	localparam int DBITS = $clog2(DIVIDER);

	logic [1:0]       rx_sync;	// Two-flop synchronizer
	logic             rx_edge;
	logic [DBITS-1:0] rx_div;
	logic             rx_sample;	// Middle of a bit
	logic [9:0]       rx_sh;	// Stop, data, start
	logic             rx_done;	// Start bit reached bit0
	byte_t            rx_buf;	// Last received byte
	logic             rx_stop;	// Stop bit of that frame
	logic [1:0]       rx_hist;	// {overrun, valid}

	// ------------------------------------------------------------
	// Line sampling
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_sync <= 2'b11;	// Idle line
		else
			rx_sync <= {rx_sync[0], rxd};
	end

	assign rx_edge   = rx_sync[1] ^ rx_sync[0];
	assign rx_sample = (rx_div == DBITS'(DIVIDER / 2 - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_div <= '0;
		else if (rx_edge || (rx_div == DBITS'(DIVIDER - 1)))
			rx_div <= '0;	// Any edge realigns the bit phase
		else
			rx_div <= rx_div + 1'b1;
	end

	// ------------------------------------------------------------
	// Frame assembly
	// ------------------------------------------------------------
	assign rx_done = ~rx_sh[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_sh <= 10'h3FF;
		else if (rx_done)
			rx_sh <= 10'h3FF;	// Ready for the next start bit
		else if (rx_sample)
			rx_sh <= {rx_sync[1], rx_sh[9:1]};
	end

	always_ff @(posedge clk) begin
		if (rx_done)
			rx_buf <= rx_sh[8:1];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_stop <= 1'b1;
		else if (rx_done)
			rx_stop <= rx_sh[9];
	end

	// Valid/overrun history, new frame wins over a read
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_hist <= 2'b00;
		else if (rx_done)
			rx_hist <= {rx_hist[0], 1'b1};	// Second frame shifts valid into overrun
		else if (rx_ack)
			rx_hist <= 2'b00;
	end

	assign rx_data      = rx_buf;
	assign rx_valid     = rx_hist[0];
	assign rx_overrun   = rx_hist[1];
	assign rx_frame_err = ~rx_stop;	// Stop bit seen low

endmodule

/* source/pwm_gen.sv */
/*
 * PWM generator
 * Free running counter with a period of 2^N - 1 clocks. The written
 * duty is copied into the active buffer at terminal count, so a new
 * value only takes effect on a whole period.
 */

`include "gus_io_defs.svh"

module pwm_gen (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     duty_wr,	// PFLAGS write, also clears flag
	input  logic [`GUS_PWM_BITS-1:0] duty,
	output logic                     pwm_out,
	output logic                     pwm_irq	// Period flag
);

	logic [`GUS_PWM_BITS-1:0] pwm_hold;	// Written duty
	logic [`GUS_PWM_BITS-1:0] pwm_buf;	// Duty for this period
	logic [`GUS_PWM_BITS-1:0] pwm_cnt;
	logic                     pwm_tc;	// Count is 2^N - 2
	logic                     pwm_zc;	// Count is zero

	assign pwm_tc = &pwm_cnt[`GUS_PWM_BITS-1:1];
	assign pwm_zc = (pwm_cnt == '0);

	// ------------------------------------------------------------
	// Duty buffers
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwm_hold <= '0;
			pwm_buf  <= '0;
		end else begin
			if (duty_wr)
				pwm_hold <= duty;
			if (pwm_tc)
				pwm_buf <= pwm_hold;	// Takes effect from next zero count
		end
	end

	// ------------------------------------------------------------
	// Counter, output and flag
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwm_cnt <= '0;
			pwm_out <= 1'b0;
			pwm_irq <= 1'b0;
		end else begin
			pwm_cnt <= pwm_tc ? '0 : pwm_cnt + 1'b1;
			if (pwm_cnt == pwm_buf)
				pwm_out <= 1'b0;	// Also keeps duty 0 low
			else if (pwm_zc)
				pwm_out <= 1'b1;
			if (pwm_zc)
				pwm_irq <= 1'b1;
			else if (duty_wr)
				pwm_irq <= 1'b0;
		end
	end

endmodule

/* source/io_regs.sv */
/*
 * GUS16 I/O register file
 * Decodes the CPU bus, holds the UART transfer while the UART is not
 * ready, and keeps interrupt enable, GPO and the screen-dirty flag.
 * Interrupt sources go through a fixed priority encoder.
 */

`include "gus_io_defs.svh"

module io_regs (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     sel,
	input  logic                     we,
	input  gus_io_pkg::reg_addr_t    addr,
	input  gus_io_pkg::word_t        wdata,
	output gus_io_pkg::word_t        rdata,
	output logic                     stall,
	input  logic [6:0]               gpi,
	output logic                     gpo,
	output logic                     irq,
	output gus_io_pkg::irq_vec_t     irq_vector,
	output logic                     tx_start,
	output gus_io_pkg::byte_t        tx_data,
	input  logic                     tx_ready,
	output logic                     rx_ack,
	input  gus_io_pkg::byte_t        rx_data,
	input  logic                     rx_valid,
	input  logic                     rx_overrun,
	input  logic                     rx_frame_err,
	output logic                     duty_wr,
	output logic [`GUS_PWM_BITS-1:0] duty,
	input  logic                     pwm_irq
);

	import gus_io_pkg::*;

	localparam byte_t CTRL_C = 8'h03;

	logic       uart_sel;	// UART offset addressed
	logic       wr;	// Accepted write
	logic       rd;	// Accepted read
	logic [2:0] irq_en;
	logic [2:0] irq_src;	// {pwm, tx ready, rx valid}
	logic [2:0] irq_act;
	logic       dirty;	// Screen needs redraw
	logic       ctrl_c;

	// ------------------------------------------------------------
	// Bus handshake
	// ------------------------------------------------------------
	assign uart_sel = sel && (addr == `GUS_REG_UART);
	// Hold reads until a byte is in, writes until TX is free
	assign stall    = uart_sel && (we ? ~tx_ready : ~rx_valid);
	assign wr       = sel && we && !stall;
	assign rd       = sel && !we && !stall;

	// Peripheral strobes
	assign tx_start = wr && (addr == `GUS_REG_UART);
	assign tx_data  = wdata[7:0];
	assign rx_ack   = rd && (addr == `GUS_REG_UART);
	assign duty_wr  = wr && (addr == `GUS_REG_PFLAGS);
	assign duty     = wdata[`GUS_PWM_BITS-1:0];

	// ------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irq_en <= 3'b000;
			gpo    <= 1'b0;
			dirty  <= 1'b0;
		end else begin
			if (wr && (addr == `GUS_REG_IRQEN))
				irq_en <= wdata[2:0];
			if (wr && (addr == `GUS_REG_GPIO))
				gpo <= wdata[0];
			if (tx_start)
				dirty <= 1'b1;	// Console output touched the screen
			else if (wr && (addr == `GUS_REG_SDCLR))
				dirty <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// Interrupts
	// ------------------------------------------------------------
	assign irq_src = {pwm_irq, tx_ready, rx_valid};
	assign irq_act = irq_src & irq_en;
	assign irq     = |irq_act;

	always_comb begin
		if (irq_act[0])
			irq_vector = 2'd0;	// Receive first
		else if (irq_act[1])
			irq_vector = 2'd1;
		else if (irq_act[2])
			irq_vector = 2'd2;
		else
			irq_vector = 2'd3;	// No source
	end

	// ------------------------------------------------------------
	// Read mux
	// ------------------------------------------------------------
	assign ctrl_c = rx_valid && (rx_data == CTRL_C);	// Break from console

	always_comb begin
		case (addr)
			`GUS_REG_IRQEN:  rdata = {13'h0, irq_en};
			`GUS_REG_PFLAGS: rdata = {9'h0, ctrl_c, dirty, pwm_irq, rx_frame_err,
			                          rx_overrun, tx_ready, rx_valid};
			`GUS_REG_UART:   rdata = {8'h0, rx_data};
			`GUS_REG_TIMER:  rdata = 16'h0;	// Timer not fitted
			`GUS_REG_GPIO:   rdata = {8'h0, gpi, gpo};
			default:         rdata = 16'h0;
		endcase
	end

endmodule

/* source/gus_io_top.sv */
/*
 * GUS16 peripheral block
 * CPU bus register file with UART, PWM, GPO and interrupt logic.
 */

`include "gus_io_defs.svh"

module gus_io_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sel,
	input  logic                  we,
	input  gus_io_pkg::reg_addr_t addr,
	input  gus_io_pkg::word_t     wdata,
	output gus_io_pkg::word_t     rdata,
	output logic                  stall,
	input  logic                  rxd,
	output logic                  txd,
	input  logic [6:0]            gpi,
	output logic                  gpo,
	output logic                  pwm_out,
	output logic                  irq,
	output gus_io_pkg::irq_vec_t  irq_vector
);

	import gus_io_pkg::*;

	// UART transmit side
	logic  tx_start;
	byte_t tx_data;
	logic  tx_ready;

	// UART receive side
	logic  rx_ack;
	byte_t rx_data;
	logic  rx_valid;
	logic  rx_overrun;
	logic  rx_frame_err;

	// PWM
	logic                     duty_wr;
	logic [`GUS_PWM_BITS-1:0] duty;
	logic                     pwm_irq;

	// ------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------
	io_regs u_io_regs (
		.clk          (clk),
		.reset        (reset),
		.sel          (sel),
		.we           (we),
		.addr         (addr),
		.wdata        (wdata),
		.rdata        (rdata),
		.stall        (stall),
		.gpi          (gpi),
		.gpo          (gpo),
		.irq          (irq),
		.irq_vector   (irq_vector),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.tx_ready     (tx_ready),
		.rx_ack       (rx_ack),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_overrun   (rx_overrun),
		.rx_frame_err (rx_frame_err),
		.duty_wr      (duty_wr),
		.duty         (duty),
		.pwm_irq      (pwm_irq)
	);

	// ------------------------------------------------------------
	// Peripherals
	// ------------------------------------------------------------
	uart_tx #(.DIVIDER(`GUS_UART_DIVIDER)) u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.txd      (txd)
	);

	uart_rx #(.DIVIDER(`GUS_UART_DIVIDER)) u_uart_rx (
		.clk          (clk),
		.reset        (reset),
		.rxd          (rxd),
		.rx_ack       (rx_ack),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_overrun   (rx_overrun),
		.rx_frame_err (rx_frame_err)
	);

	pwm_gen u_pwm_gen (
		.clk     (clk),
		.reset   (reset),
		.duty_wr (duty_wr),
		.duty    (duty),
		.pwm_out (pwm_out),
		.pwm_irq (pwm_irq)
	);

endmodule

/* dv/tb_gus_io.sv */
/*
 * Testbench for the GUS16 peripheral block
 * Drives the CPU bus, a serial line into the receiver and decodes
 * the transmitter, then checks GPIO, UART, PWM and interrupt logic
 * against a reference model.
 */

`include "gus_io_defs.svh"

module tb_gus_io;

	import gus_io_pkg::*;

	localparam int DIV   = `GUS_UART_DIVIDER;
	localparam int FRAME = 10 * DIV;
	localparam int PER   = (1 << `GUS_PWM_BITS) - 1;	// PWM period in clocks
	localparam int LIMIT = 60 * FRAME + 10 * PER;

	logic      clk;
	logic      reset;
	logic      sel;
	logic      we;
	reg_addr_t addr;
	word_t     wdata;
	word_t     rdata;
	logic      stall;
	logic      rxd;
	logic      txd;
	logic [6:0] gpi;
	logic      gpo;
	logic      pwm_out;
	logic      irq;
	irq_vec_t  irq_vector;

	logic [31:0] rng = 32'd16184;	// Xorshift state
	byte_t       exp_q[$];	// Bytes expected on txd
	int          cycles = 0;
	logic        m_dirty = 1'b0;	// Model of the dirty flag

	gus_io_top u_gus_io_top (
		.clk        (clk),
		.reset      (reset),
		.sel        (sel),
		.we         (we),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.stall      (stall),
		.rxd        (rxd),
		.txd        (txd),
		.gpi        (gpi),
		.gpo        (gpo),
		.pwm_out    (pwm_out),
		.irq        (irq),
		.irq_vector (irq_vector)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: test did not finish within %0d cycles", LIMIT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------------------------------------
	// Reference model and helpers
	// ------------------------------------------------------------
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// PFLAGS read value from the flag states
	function word_t pflags_model(input logic rxv, input logic txr, input logic ovr,
			input logic fe, input logic pirq, input logic drt, input byte_t rxb);
		logic cc;
		cc = rxv && (rxb == 8'd3);	// Ctrl-C pending
		return {9'h0, cc, drt, pirq, fe, ovr, txr, rxv};
	endfunction

	// Lowest enabled active source wins, result is {irq, vector}
	function logic [2:0] irq_priority(input logic [2:0] en, input logic rxv,
			input logic txr, input logic pf);
		logic [2:0] act;
		act = en & {pf, txr, rxv};
		if (act[0])
			return {1'b1, 2'd0};
		else if (act[1])
			return {1'b1, 2'd1};
		else if (act[2])
			return {1'b1, 2'd2};
		return {1'b0, 2'd0};	// Vector has no meaning without a source
	endfunction

	// High clocks per period for a duty
	function int duty_high_clocks(input logic [7:0] d);
		return (d >= 8'd255) ? PER : int'(d);
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("FAIL t=%0t %s", $time, msg);
			$display("TEST RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// ------------------------------------------------------------
	// Bus and serial tasks
	// ------------------------------------------------------------
	task automatic bus_write(input reg_addr_t a, input word_t d);
		@(negedge clk);
		sel   = 1'b1;
		we    = 1'b1;
		addr  = a;
		wdata = d;
		#1;
		while (stall) begin	// Held until the UART is ready
			@(negedge clk);
			#1;
		end
		@(negedge clk);	// Accepting edge has passed
		sel = 1'b0;
		we  = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t a, output word_t d);
		@(negedge clk);
		sel  = 1'b1;
		we   = 1'b0;
		addr = a;
		#1;
		while (stall) begin
			@(negedge clk);
			#1;
		end
		d = rdata;	// Combinational and stable before the edge
		@(negedge clk);
		sel = 1'b0;
	endtask

	task automatic uart_write(input byte_t b);
		exp_q.push_back(b);
		bus_write(`GUS_REG_UART, {8'h0, b});
		m_dirty = 1'b1;
	endtask

	// 8N1 frame on rxd followed by two idle bits
	task automatic send_frame(input byte_t b, input logic stop);
		logic [9:0] f;
		f = {stop, b, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			rxd = f[i];
			repeat (DIV) @(negedge clk);
		end
		rxd = 1'b1;
		repeat (2 * DIV) @(negedge clk);
	endtask

	// PFLAGS against the model with the PWM flag masked
	task automatic check_pflags(input logic rxv, input logic ovr, input logic fe,
			input byte_t rxb, input string msg);
		word_t d;
		bus_read(`GUS_REG_PFLAGS, d);
		check((d & 16'hFFEF) == (pflags_model(rxv, 1'b1, ovr, fe, 1'b0, m_dirty, rxb)
			& 16'hFFEF), msg);
	endtask

	task automatic wait_tx_idle();
		word_t d;
		while (exp_q.size() != 0)
			@(negedge clk);
		d = 16'h0;
		while (!d[1])
			bus_read(`GUS_REG_PFLAGS, d);
	endtask

	// Clear the period flag just after a zero count
	task automatic clear_pwm_flag();
		@(posedge pwm_out);
		bus_write(`GUS_REG_PFLAGS, 16'd100);
	endtask

	task automatic check_masks(input logic rxv, input logic txr, input logic pf);
		logic [2:0]  en;
		logic [2:0]  e;
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r  = next_rand();
			en = (i == 7) ? 3'b111 : r[2:0];
			bus_write(`GUS_REG_IRQEN, {13'h0, en});
			e = irq_priority(en, rxv, txr, pf);
			check(irq == e[2] && (!e[2] || irq_vector == e[1:0]),
				$sformatf("irq/vector for mask %b", en));
		end
	endtask

	// ------------------------------------------------------------
	// txd monitor comparing every decoded byte
	// ------------------------------------------------------------
	initial begin
		byte_t b;
		byte_t e;
		forever begin
			@(negedge clk);
			if (!reset && txd == 1'b0) begin
				repeat (DIV / 2) @(negedge clk);	// Middle of start bit
				check(txd == 1'b0, "txd start bit");
				for (int i = 0; i < 8; i++) begin
					repeat (DIV) @(negedge clk);
					b[i] = txd;	// LSB first
				end
				repeat (DIV) @(negedge clk);
				check(txd == 1'b1, "txd stop bit");
				e = (exp_q.size() != 0) ? exp_q.pop_front() : ~b;
				check(b == e, $sformatf("txd byte %h, expected %h", b, e));
			end
		end
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		word_t       d;
		logic [31:0] r;
		byte_t       b;
		byte_t       b2;
		logic [7:0]  duty;
		int          hi;
		reset = 1'b1;
		sel   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		rxd   = 1'b1;
		gpi   = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		// 1. Reset values, the PWM flag sets on the first zero count
		check(txd && !pwm_out && !irq && !gpo, "outputs after reset");
		bus_read(`GUS_REG_IRQEN, d);
		check(d == 16'h0, "IRQEN after reset");
		bus_read(`GUS_REG_PFLAGS, d);
		check((d & 16'h006D) == 16'h0 && d[1], "PFLAGS after reset");
		bus_read(`GUS_REG_TIMER, d);
		check(d == 16'h0, "timer offset reads zero");

		// 2. GPIO
		for (int i = 0; i < 4; i++) begin
			r   = next_rand();
			gpi = r[6:0];
			bus_write(`GUS_REG_GPIO, {15'h0, r[7]});
			check(gpo == r[7], "gpo value");
			bus_read(`GUS_REG_GPIO, d);
			check(d == {8'h0, r[6:0], r[7]}, "GPIO read back");
		end

		// 3. UART transmit with a write stalled behind the first
		r = next_rand();
		uart_write(r[7:0]);
		r = next_rand();
		fork
			uart_write(r[7:0]);
			begin
				repeat (3) @(negedge clk);
				check(stall, "UART write while busy stalls");
			end
		join
		for (int i = 0; i < 2; i++) begin
			r = next_rand();
			uart_write(r[7:0]);
		end
		bus_read(`GUS_REG_PFLAGS, d);
		check(d[5], "dirty set by UART write");
		bus_write(`GUS_REG_SDCLR, 16'h0);
		m_dirty = 1'b0;
		bus_read(`GUS_REG_PFLAGS, d);
		check(!d[5], "dirty cleared");
		wait_tx_idle();

		// 4. UART receive where an empty read stalls until the frame is in
		r = next_rand();
		b = r[7:0];
		fork
			send_frame(b, 1'b1);
			bus_read(`GUS_REG_UART, d);
			begin
				repeat (5) @(negedge clk);
				check(stall, "empty UART read stalls");
			end
		join
		check(d == {8'h0, b}, "received byte");
		r  = next_rand();
		b  = r[7:0];
		r  = next_rand();
		b2 = r[7:0];
		send_frame(b, 1'b1);
		send_frame(b2, 1'b1);
		check_pflags(1'b1, 1'b1, 1'b0, b2, "overrun set");
		bus_read(`GUS_REG_UART, d);
		check(d == {8'h0, b2}, "overrun keeps last byte");
		check_pflags(1'b0, 1'b0, 1'b0, b2, "overrun cleared by read");
		r = next_rand();
		b = r[7:0];
		send_frame(b, 1'b0);
		check_pflags(1'b1, 1'b0, 1'b1, b, "frame error");
		bus_read(`GUS_REG_UART, d);
		send_frame(8'd3, 1'b1);
		check_pflags(1'b1, 1'b0, 1'b0, 8'd3, "ctrl_c flag");
		bus_read(`GUS_REG_UART, d);
		check(d == 16'd3, "ctrl_c byte");

		// 5. PWM duty counted over one full period after the copy
		for (int i = 0; i < 6; i++) begin
			r    = next_rand();
			duty = (i == 0) ? 8'd0 : (i == 1) ? 8'd255 : r[7:0];
			bus_write(`GUS_REG_PFLAGS, {8'h0, duty});
			repeat (2 * PER + 4) @(negedge clk);
			hi = 0;
			for (int c = 0; c < PER; c++) begin
				@(negedge clk);
				if (pwm_out)
					hi++;
			end
			check(hi == duty_high_clocks(duty),
				$sformatf("PWM high %0d for duty %0d", hi, duty));
		end
		bus_write(`GUS_REG_PFLAGS, 16'd100);
		repeat (2 * PER) @(negedge clk);
		bus_read(`GUS_REG_PFLAGS, d);
		check(d[4], "pwm_irq set");
		clear_pwm_flag();
		bus_read(`GUS_REG_PFLAGS, d);
		check(!d[4], "pwm_irq cleared");

		// 6. Interrupts with all sources and then fewer
		r = next_rand();
		b = r[7:0];
		send_frame(b, 1'b1);
		repeat (PER + 2) @(negedge clk);	// Period flag set again
		check_masks(1'b1, 1'b1, 1'b1);
		r = next_rand();
		uart_write(r[7:0]);	// Transmitter busy for a frame
		clear_pwm_flag();
		check_masks(1'b1, 1'b0, 1'b0);
		bus_read(`GUS_REG_UART, d);
		check(d == {8'h0, b}, "pending byte");
		check_masks(1'b0, 1'b0, 1'b0);
		wait_tx_idle();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+source
source/gus_io_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/pwm_gen.sv
source/io_regs.sv
source/gus_io_top.sv
dv/tb_gus_io.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the GUS16 I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_gus_io -o tb_gus_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_gus_io > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
